// ==== host_mem_bridge.f ====
rtl/host_mem_pkg.sv
rtl/chunk_if.sv
rtl/burst_splitter.sv
rtl/line_req_mapper.sv
rtl/resp_mapper.sv
rtl/host_mem_bridge.sv
testbench/host_mem_model.sv
testbench/tb_host_mem_bridge.sv

// ==== Bender.yml ====
package:
  name: host_mem_bridge

sources:
  - rtl/host_mem_pkg.sv
  - rtl/chunk_if.sv
  - rtl/burst_splitter.sv
  - rtl/line_req_mapper.sv
  - rtl/resp_mapper.sv
  - rtl/host_mem_bridge.sv
  - target: test
    files:
      - testbench/host_mem_model.sv
      - testbench/tb_host_mem_bridge.sv

// ==== testbench/tb_host_mem_bridge.sv ====
// Testbench for the host memory bridge. Issues accelerator commands one at a time,
// checks every host header and beat against the split rule, and compares read data
// and response counts with a shadow copy of the written lines.

`timescale 1ns/1ps

module tb_host_mem_bridge;
    import host_mem_pkg::*;

    localparam int num_cmds = 66;
    localparam int timeout_cycles = num_cmds * 16 * 20 + 1000;

    typedef struct packed
    {
        logic       write;
        t_line_addr addr;
        t_cl_len    cl_len;
        logic       last;
    } chunk_t;

    logic       clk;
    logic       reset_n;
    logic       bp_enable;
    logic       cmd_valid, cmd_ready, cmd_write;
    t_line_addr cmd_addr;
    t_burst_len cmd_len;
    logic       wdata_valid, wdata_ready;
    t_line      wdata;
    logic       rd_resp_valid, wr_resp_valid;
    t_line      rd_resp_data;
    logic       c0_tx_valid, c1_tx_valid, c1_tx_sop;
    t_line_addr c0_tx_addr, c1_tx_addr;
    t_cl_len    c0_tx_cl_len, c1_tx_cl_len;
    t_line      c1_tx_data, c0_rx_data;
    logic [7:0] c1_tx_mdata, c1_rx_mdata;
    logic       c0_almost_full, c1_almost_full, c0_rx_valid, c1_rx_valid;

    // Expected chunks, read lines and write beat data, and the lines still to be driven
    chunk_t exp_q[$];
    t_line  exp_rd[$];
    logic   exp_known[$];
    t_line  exp_wd[$];
    t_line  wd_q[$];
    t_line  shadow [t_line_addr];

    chunk_t pkt;
    int     beat_idx = 0;
    int     hdr_count = 0;
    int     rd_resp_count = 0;
    int     rd_lines = 0;
    int     wr_resp_count = 0;
    int     wr_cmds = 0;
    int     err_count = 0;
    int     pass_tests = 0;
    int     fail_tests = 0;
    int     cycles = 0;

    host_mem_bridge u_dut (.*);

    host_mem_model u_host (.*);

    always #5 clk = ~clk;

    // ==================================================
    // Reference and check helpers
    // ==================================================

    // Largest aligned chunk that fits, repeated until the burst is used up
    function automatic void split_chunks(input logic write, input int addr, input int len);
        int     a;
        int     r;
        int     n;
        chunk_t c;
        a = addr;
        r = len;
        while (r > 0)
        begin
            if ((a % 4 == 0) && (r >= 4))
                n = 4;
            else if ((a % 2 == 0) && (r >= 2))
                n = 2;
            else
                n = 1;
            c.write = write;
            c.addr = t_line_addr'(a);
            c.cl_len = t_cl_len'(n - 1);
            r = r - n;
            a = a + n;
            c.last = (r == 0);
            exp_q.push_back(c);
        end
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // One full command, returning once its responses are all back
    task automatic run_cmd(input logic write, input int addr, input int len);
        int         i;
        int         start;
        t_line      d;
        t_line_addr a;
        split_chunks(write, addr, len);
        for (i = 0; i < len; i++)
        begin
            a = t_line_addr'(addr + i);
            if (write)
            begin
                d = {$urandom, $urandom};
                shadow[a] = d;
                wd_q.push_back(d);
                exp_wd.push_back(d);
            end
            else
            begin
                exp_known.push_back(shadow.exists(a));
                exp_rd.push_back(shadow.exists(a) ? shadow[a] : '0);
            end
        end
        start = write ? wr_resp_count : rd_resp_count;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_write <= write;
        cmd_addr <= t_line_addr'(addr);
        cmd_len <= t_burst_len'(len);
        do
            @(posedge clk);
        while (!cmd_ready);
        cmd_valid <= 1'b0;
        if (write)
        begin
            wr_cmds++;
            while (wr_resp_count == start)
                @(posedge clk);
        end
        else
        begin
            rd_lines += len;
            while (rd_resp_count < start + len)
                @(posedge clk);
        end
    endtask

    // Lets the host drain, then checks that nothing is missing or left over
    task automatic end_test(input string name, input int err_start);
        repeat (20) @(posedge clk);
        check_eq("wr_resp_valid count", wr_resp_count, wr_cmds);
        check_eq("pending chunks", exp_q.size(), 0);
        check_eq("rd_resp_valid count", rd_resp_count, rd_lines);
        if (err_count == err_start)
        begin
            pass_tests++;
            $display("test %s: ok", name);
        end
        else
        begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_count - err_start);
        end
    endtask

    // ==================================================
    // Drivers and monitors
    // ==================================================

    // Write data follows the queue, one line per accepted transfer
    always @(posedge clk)
    begin
        if (wdata_valid && wdata_ready)
            void'(wd_q.pop_front());
        wdata_valid <= (wd_q.size() > 0);
        if (wd_q.size() > 0)
            wdata <= wd_q[0];
    end

    // Headers and beats are compared in order with the reference chunk list
    always @(posedge clk)
    begin
        chunk_t c;
        if (reset_n && c0_tx_valid)
        begin
            hdr_count++;
            if (exp_q.size() == 0)
            begin
                err_count++;
                $display("Read header at %h arrived with no chunk expected", c0_tx_addr);
            end
            else
            begin
                c = exp_q.pop_front();
                check_eq("chunk write flag", 0, c.write);
                check_eq("c0_tx_addr", c0_tx_addr, c.addr);
                check_eq("c0_tx_cl_len", c0_tx_cl_len, c.cl_len);
            end
        end
        if (reset_n && c1_tx_valid)
        begin
            if (beat_idx == 0)
            begin
                hdr_count++;
                if (exp_q.size() == 0)
                begin
                    err_count++;
                    $display("Write packet at %h arrived with no chunk expected", c1_tx_addr);
                end
                else
                begin
                    pkt = exp_q.pop_front();
                    check_eq("chunk write flag", 1, pkt.write);
                end
            end
            check_eq("c1_tx_sop", c1_tx_sop, beat_idx == 0);
            check_eq("c1_tx_addr", c1_tx_addr, t_line_addr'(pkt.addr + beat_idx));
            check_eq("c1_tx_cl_len", c1_tx_cl_len, pkt.cl_len);
            check_eq("c1_tx_mdata", c1_tx_mdata, {7'b0, pkt.last});
            // Beats carry the accelerator lines in command order
            if (exp_wd.size() > 0)
                check_eq("c1_tx_data", c1_tx_data, exp_wd.pop_front());
            else
            begin
                err_count++;
                $display("Write beat at %h arrived with no data line expected", c1_tx_addr);
            end
            beat_idx = (beat_idx == int'(pkt.cl_len)) ? 0 : beat_idx + 1;
        end
    end

    // Accelerator responses
    always @(posedge clk)
    begin
        t_line d;
        logic  known;
        if (reset_n && rd_resp_valid)
        begin
            rd_resp_count++;
            if (exp_rd.size() == 0)
            begin
                err_count++;
                $display("Read response arrived with no line outstanding");
            end
            else
            begin
                d = exp_rd.pop_front();
                known = exp_known.pop_front();
                if (known)
                    check_eq("rd_resp_data", rd_resp_data, d);
            end
        end
        if (reset_n && wr_resp_valid)
            wr_resp_count++;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeout_cycles)
        begin
            $display("Timeout after %0d cycles, a command never completed", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        int i;
        int e0;
        int h0;
        int addr_a[8];
        int len_a[8];
        clk = 1'b0;
        reset_n = 1'b0;
        bp_enable = 1'b0;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr = '0;
        cmd_len = t_burst_len'(1);
        wdata_valid = 1'b0;
        wdata = '0;
        void'($urandom(32'hd017d20c));
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        // Sampled in the first cycle with reset released
        e0 = err_count;
        @(negedge clk);
        check_eq("cmd_ready", cmd_ready, 0);
        check_eq("wdata_ready", wdata_ready, 0);
        check_eq("c0_tx_valid", c0_tx_valid, 0);
        check_eq("c1_tx_valid", c1_tx_valid, 0);
        check_eq("rd_resp_valid", rd_resp_valid, 0);
        check_eq("wr_resp_valid", wr_resp_valid, 0);
        check_eq("chunk valid", u_dut.chunk.valid, 0);
        end_test("reset", e0);

        // Aligned 1, 2 and 4 line writes, then reads of the same lines
        e0 = err_count;
        for (i = 0; i < 6; i++)
        begin
            h0 = hdr_count;
            run_cmd(i < 3, 'h100 + (i % 3) * 8, 1 << (i % 3));
            check_eq("headers per aligned command", hdr_count - h0, 1);
        end
        end_test("aligned", e0);

        e0 = err_count;
        for (i = 0; i < 20; i++)
            run_cmd($urandom_range(1, 0), 'h2000 + $urandom_range(63, 0), $urandom_range(16, 1));
        end_test("split", e0);

        e0 = err_count;
        for (i = 0; i < 8; i++)
        begin
            addr_a[i] = 'h3000 + i * 32 + $urandom_range(7, 0);
            len_a[i] = $urandom_range(16, 1);
            run_cmd(1'b1, addr_a[i], len_a[i]);
        end
        for (i = 0; i < 8; i++)
            run_cmd(1'b0, addr_a[i], len_a[i]);
        end_test("readback", e0);

        // Odd start addresses force several packets per write
        e0 = err_count;
        for (i = 0; i < 8; i++)
            run_cmd(1'b1, 'h4001 + i * 32, $urandom_range(16, 5));
        end_test("write_resp", e0);

        @(posedge clk);
        bp_enable <= 1'b1;
        e0 = err_count;
        for (i = 0; i < 8; i++)
        begin
            addr_a[i] = 'h5000 + i * 32 + $urandom_range(15, 0);
            len_a[i] = $urandom_range(16, 1);
            run_cmd(1'b1, addr_a[i], len_a[i]);
        end
        for (i = 0; i < 8; i++)
            run_cmd(1'b0, addr_a[i], len_a[i]);
        end_test("backpressure", e0);

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 pass_tests, fail_tests, err_count);
        if ((fail_tests == 0) && (err_count == 0))
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== testbench/host_mem_model.sv ====
// Host channel model for the bridge testbench. Stores written lines, returns read
// lines in request order after a random delay and answers each write packet once.
// Almost-full rises when a queue fills up, and at random while bp_enable is high.

`timescale 1ns/1ps

module host_mem_model
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     bp_enable,
    input  logic                     c0_tx_valid,
    input  host_mem_pkg::t_line_addr c0_tx_addr,
    input  host_mem_pkg::t_cl_len    c0_tx_cl_len,
    input  logic                     c1_tx_valid,
    input  host_mem_pkg::t_line_addr c1_tx_addr,
    input  host_mem_pkg::t_cl_len    c1_tx_cl_len,
    input  logic                     c1_tx_sop,
    input  host_mem_pkg::t_line      c1_tx_data,
    input  logic [7:0]               c1_tx_mdata,
    output logic                     c0_almost_full,
    output logic                     c1_almost_full,
    output logic                     c0_rx_valid,
    output host_mem_pkg::t_line      c0_rx_data,
    output logic                     c1_rx_valid,
    output logic [7:0]               c1_rx_mdata
);
    import host_mem_pkg::*;

    localparam int queue_depth = 8;

    // Line memory, sparse because only a few ranges are ever touched
    t_line      mem [t_line_addr];
    t_line_addr rd_q[$];
    logic [7:0] wr_q[$];
    int         beats_left;

    // Lines never written read back as a pattern built from the whole address
    function automatic t_line fill_line(input t_line_addr a);
        return {a, ~a, a ^ 16'h5a5a, a};
    endfunction

    initial
    begin
        c0_almost_full = 1'b0;
        c1_almost_full = 1'b0;
        c0_rx_valid = 1'b0;
        c0_rx_data = '0;
        c1_rx_valid = 1'b0;
        c1_rx_mdata = '0;
        beats_left = 0;
    end

    always @(posedge clk)
    begin
        int         i;
        t_line_addr a;
        if (!reset_n)
        begin
            rd_q.delete();
            wr_q.delete();
            beats_left = 0;
            c0_almost_full <= 1'b0;
            c1_almost_full <= 1'b0;
            c0_rx_valid <= 1'b0;
            c1_rx_valid <= 1'b0;
        end
        else
        begin
            // A read header queues every line of its packet
            if (c0_tx_valid)
            begin
                for (i = 0; i <= int'(c0_tx_cl_len); i++)
                    rd_q.push_back(c0_tx_addr + t_line_addr'(i));
            end
            // Write beats land in memory, the packet answers after its last beat
            if (c1_tx_valid)
            begin
                mem[c1_tx_addr] = c1_tx_data;
                if (c1_tx_sop)
                    beats_left = int'(c1_tx_cl_len) + 1;
                beats_left = beats_left - 1;
                if (beats_left == 0)
                    wr_q.push_back(c1_tx_mdata);
            end

            // Responses leave in order, each one held back by a random stall
            c0_rx_valid <= 1'b0;
            c1_rx_valid <= 1'b0;
            if ((rd_q.size() > 0) && ($urandom_range(3, 0) != 0))
            begin
                a = rd_q.pop_front();
                c0_rx_valid <= 1'b1;
                c0_rx_data <= mem.exists(a) ? mem[a] : fill_line(a);
            end
            if ((wr_q.size() > 0) && ($urandom_range(3, 0) != 0))
            begin
                c1_rx_valid <= 1'b1;
                c1_rx_mdata <= wr_q.pop_front();
            end

            c0_almost_full <= (rd_q.size() > queue_depth - 2) ||
                              (bp_enable && ($urandom_range(3, 0) == 0));
            c1_almost_full <= (wr_q.size() > queue_depth - 2) ||
                              (bp_enable && ($urandom_range(3, 0) == 0));
        end
    end

endmodule

// ==== rtl/host_mem_bridge.sv ====
// Top level of the host memory bridge. Connects the accelerator command, write
// data and response ports to the line-oriented host channel through the
// splitter, the request mapper and the response mapper.

`timescale 1ns/1ps

module host_mem_bridge
(
    input  logic                     clk,
    input  logic                     reset_n,

    // Accelerator commands and write data
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic                     cmd_write,
    input  host_mem_pkg::t_line_addr cmd_addr,
    input  host_mem_pkg::t_burst_len cmd_len,
    input  logic                     wdata_valid,
    output logic                     wdata_ready,
    input  host_mem_pkg::t_line      wdata,

    // Accelerator responses
    output logic                     rd_resp_valid,
    output host_mem_pkg::t_line      rd_resp_data,
    output logic                     wr_resp_valid,

    // Host channel requests
    output logic                     c0_tx_valid,
    output host_mem_pkg::t_line_addr c0_tx_addr,
    output host_mem_pkg::t_cl_len    c0_tx_cl_len,
    output logic                     c1_tx_valid,
    output host_mem_pkg::t_line_addr c1_tx_addr,
    output host_mem_pkg::t_cl_len    c1_tx_cl_len,
    output logic                     c1_tx_sop,
    output host_mem_pkg::t_line      c1_tx_data,
    output logic [7:0]               c1_tx_mdata,

    // Host channel flow control and responses
    input  logic                     c0_almost_full,
    input  logic                     c1_almost_full,
    input  logic                     c0_rx_valid,
    input  host_mem_pkg::t_line      c0_rx_data,
    input  logic                     c1_rx_valid,
    input  logic [7:0]               c1_rx_mdata
);

    // Legal chunks from the splitter to the mapper
    chunk_if chunk();

    burst_splitter u_splitter
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .chunk     (chunk.src)
    );

    line_req_mapper u_req_mapper
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .chunk          (chunk.dst),
        .wdata_valid    (wdata_valid),
        .wdata_ready    (wdata_ready),
        .wdata          (wdata),
        .c0_almost_full (c0_almost_full),
        .c1_almost_full (c1_almost_full),
        .c0_tx_valid    (c0_tx_valid),
        .c0_tx_addr     (c0_tx_addr),
        .c0_tx_cl_len   (c0_tx_cl_len),
        .c1_tx_valid    (c1_tx_valid),
        .c1_tx_addr     (c1_tx_addr),
        .c1_tx_cl_len   (c1_tx_cl_len),
        .c1_tx_sop      (c1_tx_sop),
        .c1_tx_data     (c1_tx_data),
        .c1_tx_mdata    (c1_tx_mdata)
    );

    resp_mapper u_resp_mapper
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .c0_rx_valid   (c0_rx_valid),
        .c0_rx_data    (c0_rx_data),
        .c1_rx_valid   (c1_rx_valid),
        .c1_rx_mdata   (c1_rx_mdata),
        .rd_resp_valid (rd_resp_valid),
        .rd_resp_data  (rd_resp_data),
        .wr_resp_valid (wr_resp_valid)
    );

endmodule

// ==== rtl/resp_mapper.sv ====
// Output side of the bridge. Forwards the host's sorted read lines to the
// accelerator and turns tagged write packet responses into command responses.

`timescale 1ns/1ps

module resp_mapper
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                c0_rx_valid,
    input  host_mem_pkg::t_line c0_rx_data,
    input  logic                c1_rx_valid,
    input  logic [7:0]          c1_rx_mdata,
    output logic                rd_resp_valid,
    output host_mem_pkg::t_line rd_resp_data,
    output logic                wr_resp_valid
);
    import host_mem_pkg::*;

    // Strobes are cleared in reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_resp_valid <= 1'b0;
            wr_resp_valid <= 1'b0;
        end
        else
        begin
            // Host read lines already come back in request order
            rd_resp_valid <= c0_rx_valid;
            // A command split into several packets tags only its last one,
            // so the accelerator sees a single write response
            wr_resp_valid <= c1_rx_valid && c1_rx_mdata[mdata_resp_bit];
        end
    end

    // Read data follows its strobe through one register stage
    always_ff @(posedge clk)
    begin
        rd_resp_data <= c0_rx_data;
    end

endmodule

// ==== rtl/line_req_mapper.sv ====
// Processing part of the bridge. Read chunks become channel 0 request headers and
// write chunks become channel 1 beats, one per line of accelerator write data.
// Almost-full levels from the host are registered into the local ready signals.

`timescale 1ns/1ps

module line_req_mapper
(
    input  logic                     clk,
    input  logic                     reset_n,
    chunk_if.dst                     chunk,
    input  logic                     wdata_valid,
    output logic                     wdata_ready,
    input  host_mem_pkg::t_line      wdata,
    input  logic                     c0_almost_full,
    input  logic                     c1_almost_full,
    output logic                     c0_tx_valid,
    output host_mem_pkg::t_line_addr c0_tx_addr,
    output host_mem_pkg::t_cl_len    c0_tx_cl_len,
    output logic                     c1_tx_valid,
    output host_mem_pkg::t_line_addr c1_tx_addr,
    output host_mem_pkg::t_cl_len    c1_tx_cl_len,
    output logic                     c1_tx_sop,
    output host_mem_pkg::t_line      c1_tx_data,
    output logic [7:0]               c1_tx_mdata
);
    import host_mem_pkg::*;

    // Registered inverse of the almost-full levels
    logic       c0_ok;
    logic       c1_ok;

    // Write data phase of one chunk
    logic       wr_phase;
    logic       wr_sop;
    logic [1:0] wr_idx;
    t_cl_len    wr_len;
    t_line_addr wr_addr;
    logic       wr_last;

    logic       chunk_xfer;
    logic       beat_xfer;
    logic       beat_end;

    // No new chunk is taken while write lines of the current one are pending
    assign chunk.ready = c0_ok && !wr_phase;
    assign wdata_ready = c1_ok && wr_phase;

    assign chunk_xfer = chunk.valid && chunk.ready;
    assign beat_xfer = wdata_valid && wdata_ready;
    // Line index reaches the encoded length on the final line of the packet
    assign beat_end = (wr_idx == 2'(wr_len));

    // ==================================================
    // Control state
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            c0_ok <= 1'b0;
            c1_ok <= 1'b0;
            c0_tx_valid <= 1'b0;
            c1_tx_valid <= 1'b0;
            wr_phase <= 1'b0;
            wr_sop <= 1'b1;
            wr_idx <= 2'd0;
        end
        else
        begin
            c0_ok <= !c0_almost_full;
            c1_ok <= !c1_almost_full;
            // A read chunk is a single header one cycle after it arrives
            c0_tx_valid <= chunk_xfer && !chunk.write;
            c1_tx_valid <= beat_xfer;

            if (chunk_xfer && chunk.write)
            begin
                wr_phase <= 1'b1;
                wr_sop <= 1'b1;
                wr_idx <= 2'd0;
            end
            else if (beat_xfer)
            begin
                wr_sop <= 1'b0;
                wr_idx <= wr_idx + 2'd1;
                if (beat_end)
                begin
                    wr_phase <= 1'b0;
                end
            end
        end
    end

    // ==================================================
    // Header and beat payload
    // ==================================================

    always_ff @(posedge clk)
    begin
        c0_tx_addr <= chunk.addr;
        c0_tx_cl_len <= chunk.cl_len;

        // Remember the write chunk header for its data phase
        if (chunk_xfer && chunk.write)
        begin
            wr_addr <= chunk.addr;
            wr_len <= chunk.cl_len;
            wr_last <= chunk.last;
        end

        // Every beat carries the packet length and its own line address
        if (beat_xfer)
        begin
            c1_tx_addr <= wr_addr + t_line_addr'(wr_idx);
            c1_tx_cl_len <= wr_len;
            c1_tx_sop <= wr_sop;
            c1_tx_data <= wdata;
            c1_tx_mdata <= '0;
            // Only the last packet of a command asks for a response
            c1_tx_mdata[mdata_resp_bit] <= wr_last;
        end
    end

    // The splitter hands over only naturally aligned chunks
    a_chunk_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        chunk_xfer |-> ((chunk.addr & t_line_addr'(chunk.cl_len)) == '0));

endmodule

// ==== rtl/burst_splitter.sv ====
// Input side of the bridge. Cuts accelerator bursts of 1 to 16 lines at any
// address into naturally aligned 1, 2 or 4 line chunks for the request mapper.
// One command is split at a time and cmd_ready stays low until its last chunk leaves.

`timescale 1ns/1ps

module burst_splitter
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic                     cmd_write,
    input  host_mem_pkg::t_line_addr cmd_addr,
    input  host_mem_pkg::t_burst_len cmd_len,
    chunk_if.src                     chunk
);
    import host_mem_pkg::*;

    // Address of the next chunk and the lines still to send, this chunk included
    t_line_addr cur_addr;
    t_burst_len remaining;
    logic       write_flag;

    t_cl_len    cur_len;
    t_burst_len cur_lines;

    // Pick the largest chunk that is aligned at the current address and fits
    always_comb
    begin
        if ((cur_addr[1:0] == 2'b00) && (remaining >= t_burst_len'(4)))
        begin
            cur_len = cl_len_4;
        end
        else if (!cur_addr[0] && (remaining >= t_burst_len'(2)))
        begin
            cur_len = cl_len_2;
        end
        else
        begin
            cur_len = cl_len_1;
        end
    end

    assign cur_lines = t_burst_len'(cur_len) + t_burst_len'(1);

    assign chunk.addr = cur_addr;
    assign chunk.write = write_flag;
    assign chunk.cl_len = cur_len;
    // The command ends when this chunk covers all remaining lines
    assign chunk.last = (remaining == cur_lines);

    // ==================================================
    // Command and chunk handshakes
    // ==================================================

    // Chunk valid stays high for the whole command, so it also marks the busy state
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cmd_ready <= 1'b0;
            chunk.valid <= 1'b0;
        end
        else if (cmd_valid && cmd_ready)
        begin
            cmd_ready <= 1'b0;
            chunk.valid <= 1'b1;
        end
        else if (chunk.valid && chunk.ready)
        begin
            if (chunk.last)
            begin
                chunk.valid <= 1'b0;
                cmd_ready <= 1'b1;
            end
        end
        else if (!chunk.valid)
        begin
            cmd_ready <= 1'b1;
        end
    end

    // Load a new command or step past the chunk that just left
    always_ff @(posedge clk)
    begin
        if (cmd_valid && cmd_ready)
        begin
            cur_addr <= cmd_addr;
            remaining <= cmd_len;
            write_flag <= cmd_write;
        end
        else if (chunk.valid && chunk.ready)
        begin
            cur_addr <= cur_addr + t_line_addr'(cur_lines);
            remaining <= remaining - cur_lines;
        end
    end

    // Accepted bursts must fit the supported length range
    a_cmd_len: assert property (@(posedge clk) disable iff (!reset_n)
        cmd_valid && cmd_ready |->
            (cmd_len >= t_burst_len'(1)) && (cmd_len <= t_burst_len'(max_burst_lines)));

    // A waiting chunk keeps valid high and its header unchanged
    a_chunk_hold: assert property (@(posedge clk) disable iff (!reset_n)
        chunk.valid && !chunk.ready |=>
            chunk.valid && $stable(chunk.addr) && $stable(chunk.cl_len));

endmodule

// ==== rtl/chunk_if.sv ====
// Chunk header link between the burst splitter and the request mapper.
// Each transfer is one naturally aligned 1, 2 or 4 line chunk of a command.

`timescale 1ns/1ps

interface chunk_if;
    import host_mem_pkg::*;

    // Handshake. A chunk moves when valid and ready are both high
    logic       valid;
    logic       ready;

    // Chunk header fields, stable while valid waits for ready
    logic       write;
    t_line_addr addr;
    t_cl_len    cl_len;

    // Final chunk of the accelerator command
    logic       last;

    // The splitter side produces chunks
    modport src
    (
        output valid,
        input  ready,
        output write,
        output addr,
        output cl_len,
        output last
    );

    // The mapper side consumes chunks
    modport dst
    (
        input  valid,
        output ready,
        input  write,
        input  addr,
        input  cl_len,
        input  last
    );

endinterface

// ==== rtl/host_mem_pkg.sv ====
// Shared definitions for the host memory bridge.
// Line and address widths, accelerator burst limits and the host channel chunk sizes
// are defined here and imported by the bridge blocks and the testbench.

package host_mem_pkg;

    // ==================================================
    // Sizes
    // ==================================================

    // One cache line of data, kept narrow for simulation
    localparam int line_bits = 64;
    localparam int line_addr_bits = 16;

    // Accelerator bursts run from 1 to 16 lines
    localparam int max_burst_lines = 16;
    localparam int burst_len_bits = 5;

    // Bit in the 8-bit write metadata that asks for an accelerator response
    localparam int mdata_resp_bit = 0;

    // ==================================================
    // Types
    // ==================================================

    typedef logic [line_bits-1:0] t_line;
    typedef logic [line_addr_bits-1:0] t_line_addr;
    typedef logic [burst_len_bits-1:0] t_burst_len;

    // Legal host channel burst sizes, encoded as line count minus one
    typedef enum logic [1:0]
    {
        cl_len_1 = 2'd0,
        cl_len_2 = 2'd1,
        cl_len_4 = 2'd3
    } t_cl_len;

endpackage
